/* hdl/exStage_settings.svh */
`ifndef EX_STAGE_SETTINGS_SVH
`define EX_STAGE_SETTINGS_SVH

// datapath word width
`define DATA_WIDTH 16

// one byte lane of the word
`define BYTE_WIDTH 8

// short immediate in the register view (rt slot)
`define IMM_WIDTH 4

`endif

/* hdl/exPkg.sv */
`include "exStage_settings.svh"

package exPkg;

	////////////////////////////////////////////////////////////////////////////
	// instruction encoding
	////////////////////////////////////////////////////////////////////////////

	// 4-bit opcode space, fully used
	typedef enum logic [3:0] {
		opAdd = 4'd0, opSub, opRed, opXor,
		opSll, opSra, opRor, opPaddsb,
		opLw, opSw, opLhb, opLlb,
		opB, opBr, opPcs, opHlt
	} opcodeT;

	// arithmetic, shift and memory forms: rd, rs, rt or imm4
	typedef struct packed {
		opcodeT opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [`IMM_WIDTH-1:0] rtImm;
	} regFmtT;

	// lhb/llb form: rd plus a full byte immediate
	typedef struct packed {
		opcodeT opcode;
		logic [3:0] rd;
		logic [`BYTE_WIDTH-1:0] imm8;
	} byteFmtT;

	// same 16 bits, two decodes of the low 12
	typedef union packed {
		regFmtT regFmt;
		byteFmtT byteFmt;
	} instrT;

	////////////////////////////////////////////////////////////////////////////
	// ALU control and data
	////////////////////////////////////////////////////////////////////////////

	// which unit drives the result
	typedef enum logic [1:0] {
		selCla = 2'd0,
		selXor = 2'd1,
		selShift = 2'd2
	} outSelT;

	// control word, same bit order as the legacy 7-bit ALUop
	typedef struct packed {
		outSelT outSel;
		logic sat;
		logic red;
		logic sub;
		logic [1:0] shiftOp;
	} aluOpT;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] aluA;
		logic [`DATA_WIDTH-1:0] aluB;
	} operandsT;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flagsT;

	// bit 1 mem-stage ALU out, bit 0 write-back data, 0 register file
	typedef logic [1:0] fwdSelT;

endpackage

/* hdl/aluOperandFormat.sv */
`timescale 1ns/100ps
`include "exStage_settings.svh"

module aluOperandFormat (
	input exPkg::instrT instr,
	input logic [`DATA_WIDTH-1:0] regData1,
	input logic [`DATA_WIDTH-1:0] regData2,
	input logic [`DATA_WIDTH-1:0] pcs,
	input logic [`DATA_WIDTH-1:0] aluOutMem,
	input logic [`DATA_WIDTH-1:0] writeData,
	input exPkg::fwdSelT forwardA,
	input exPkg::fwdSelT forwardB,
	output exPkg::operandsT operands,
	output exPkg::aluOpT aluOp,
	output logic [`DATA_WIDTH-1:0] regDataB
);
	import exPkg::*;

	localparam int DW = `DATA_WIDTH;
	localparam int BW = `BYTE_WIDTH;
	localparam int IW = `IMM_WIDTH;

	// opcode bits, msb first
	logic a, b, c, d;
	logic useImm, byteSelect, ldByte, memOp, pcsSelect;
	logic [IW-1:0] imm4;
	logic [BW-1:0] imm8;
	logic [DW-1:0] regDataA, alignedA, byteA, formattedA;
	logic [DW-1:0] byteB, immMem, immB, immOrRegB;

	assign {a, b, c, d} = instr.regFmt.opcode;
	assign imm4 = instr.regFmt.rtImm;
	assign imm8 = instr.byteFmt.imm8;

	//////////////////////////////////////////////////////////////////////////////
	// local decode
	//////////////////////////////////////////////////////////////////////////////

	// immediate for shifts, lw, sw, lhb, llb; register for arith and xor
	assign useImm = (a & ~b) | (b & ~c) | (~a & b & ~d);
	// llb when set, lhb when clear
	assign byteSelect = d;
	// lhb or llb
	assign ldByte = a & ~b & c;
	// lw or sw
	assign memOp = a & ~b & ~c;
	// pcs, b/br/hlt land here too but their result is don't-care
	assign pcsSelect = a & b;

	// control word for the units
	always_comb begin
		// shifter for sll/sra/ror, xor for xor only
		aluOp.outSel = outSelT'({~a & b & (~c | ~d), ~a & ~b & c & d});
		// paddsb, only meaningful on the cla path
		aluOp.sat = ~a & b;
		aluOp.red = ~a & ~b & c;
		aluOp.sub = ~a & ~b & d;
		// low opcode bits pick the shift kind
		aluOp.shiftOp = {c, d};
	end

	//////////////////////////////////////////////////////////////////////////////
	// operand A
	//////////////////////////////////////////////////////////////////////////////

	// mem-stage result wins over write-back
	assign regDataA = forwardA[1] ? aluOutMem :
		forwardA[0] ? writeData : regData1;
	// halfword addresses, drop the lsb
	assign alignedA = memOp ? {regDataA[DW-1:1], 1'b0} : regDataA;
	// keep the byte that the immediate does not replace
	assign byteA = byteSelect ? {regDataA[DW-1:BW], {BW{1'b0}}} :
		{{(DW - BW){1'b0}}, regDataA[BW-1:0]};
	assign formattedA = ldByte ? byteA : alignedA;

	//////////////////////////////////////////////////////////////////////////////
	// operand B
	//////////////////////////////////////////////////////////////////////////////

	// imm8 into the low byte for llb, high byte for lhb
	assign byteB = byteSelect ? {{(DW - BW){1'b0}}, imm8} : {imm8, {(DW - BW){1'b0}}};
	// sign extend, and scale by two for halfword offsets
	assign immMem = memOp ? {{(DW - IW - 1){imm4[IW-1]}}, imm4, 1'b0} :
		{{(DW - IW){imm4[IW-1]}}, imm4};
	assign immB = ldByte ? byteB : immMem;

	// also the store data seen by memory
	assign regDataB = forwardB[1] ? aluOutMem :
		forwardB[0] ? writeData : regData2;
	assign immOrRegB = useImm ? immB : regDataB;

	// pcs computes 0 + pcs through the adder
	assign operands = '{
		aluA: pcsSelect ? {DW{1'b0}} : formattedA,
		aluB: pcsSelect ? pcs : immOrRegB
	};

endmodule

/* hdl/claArith.sv */
`timescale 1ns/100ps
`include "exStage_settings.svh"

module claArith (
	input exPkg::operandsT operands,
	input exPkg::aluOpT aluOp,
	output logic [`DATA_WIDTH-1:0] claResult,
	output logic claOverflow
);
	import exPkg::*;

	localparam int DW = `DATA_WIDTH;
	localparam int BW = `BYTE_WIDTH;
	localparam int GROUPS = DW / 4;

	logic [DW-1:0] opA, opB, gen, prop, carry, sum;
	// top group terms are not needed, no carry out is used
	logic [GROUPS-2:0] groupGen, groupProp;
	logic wordOvf, loOvf;
	logic [DW-1:0] wordSat;
	logic [BW-1:0] hiLane, loLane;
	logic signed [BW+1:0] redSum;

	// byte sign extended to reduction width
	function automatic logic signed [BW+1:0] sextByte(input logic [BW-1:0] val);
		sextByte = {{2{val[BW-1]}}, val};
	endfunction

	assign opA = operands.aluA;
	// two's complement subtract, carry-in supplied below
	assign opB = aluOp.sub ? ~operands.aluB : operands.aluB;
	assign gen = opA & opB;
	assign prop = opA ^ opB;

	//////////////////////////////////////////////////////////////////////////////
	// 4-bit lookahead groups
	//////////////////////////////////////////////////////////////////////////////

	for (genvar gi = 0; gi < GROUPS; gi++) begin : gGroup
		localparam int base = 4 * gi;
		// internal carries from the group carry-in
		assign carry[base+1] = gen[base] | (prop[base] & carry[base]);
		assign carry[base+2] = gen[base+1] | (prop[base+1] & gen[base]) |
			(prop[base+1] & prop[base] & carry[base]);
		assign carry[base+3] = gen[base+2] | (prop[base+2] & gen[base+1]) |
			(prop[base+2] & prop[base+1] & gen[base]) |
			(prop[base+2] & prop[base+1] & prop[base] & carry[base]);
		if (gi < GROUPS - 1) begin : gTerms
			assign groupGen[gi] = gen[base+3] | (prop[base+3] & gen[base+2]) |
				(prop[base+3] & prop[base+2] & gen[base+1]) |
				(prop[base+3] & prop[base+2] & prop[base+1] & gen[base]);
			assign groupProp[gi] = &prop[base+3:base];
		end
	end

	// second level, carries into groups 1..3
	assign carry[0] = aluOp.sub;
	assign carry[4] = groupGen[0] | (groupProp[0] & carry[0]);
	// paddsb cuts the chain between the byte lanes
	assign carry[8] = ~aluOp.sat & (groupGen[1] | (groupProp[1] & groupGen[0]) |
		(groupProp[1] & groupProp[0] & carry[0]));
	assign carry[12] = groupGen[2] | (groupProp[2] & carry[8]);

	assign sum = prop ^ carry;

	//////////////////////////////////////////////////////////////////////////////
	// saturation and reduction
	//////////////////////////////////////////////////////////////////////////////

	// same-sign inputs, different-sign sum; also the high lane check for paddsb
	assign wordOvf = (opA[DW-1] == opB[DW-1]) & (sum[DW-1] != opA[DW-1]);
	assign loOvf = (opA[BW-1] == opB[BW-1]) & (sum[BW-1] != opA[BW-1]);

	// clamp towards the sign of the inputs
	assign wordSat = !wordOvf ? sum :
		opA[DW-1] ? {1'b1, {(DW - 1){1'b0}}} : {1'b0, {(DW - 1){1'b1}}};
	assign hiLane = !wordOvf ? sum[DW-1:BW] :
		opA[DW-1] ? {1'b1, {(BW - 1){1'b0}}} : {1'b0, {(BW - 1){1'b1}}};
	assign loLane = !loOvf ? sum[BW-1:0] :
		opA[BW-1] ? {1'b1, {(BW - 1){1'b0}}} : {1'b0, {(BW - 1){1'b1}}};

	// two-level tree over the four signed bytes, cannot overflow 10 bits
	assign redSum = (sextByte(opA[DW-1:BW]) + sextByte(opA[BW-1:0])) +
		(sextByte(opB[DW-1:BW]) + sextByte(opB[BW-1:0]));

	always_comb begin
		if (aluOp.red)
			claResult = {{(DW - BW - 2){redSum[BW+1]}}, redSum};
		else if (aluOp.sat)
			claResult = {hiLane, loLane};
		else
			claResult = wordSat;
	end

	// reported for full-word sums only
	assign claOverflow = wordOvf & ~aluOp.sat & ~aluOp.red;

endmodule

/* hdl/shiftXor.sv */
`timescale 1ns/100ps
`include "exStage_settings.svh"

module shiftXor (
	input exPkg::operandsT operands,
	input exPkg::aluOpT aluOp,
	output logic [`DATA_WIDTH-1:0] shiftResult,
	output logic [`DATA_WIDTH-1:0] xorResult
);
	import exPkg::*;

	localparam int DW = `DATA_WIDTH;
	localparam int STAGES = 4;

	// stage[0] is the input, stage[STAGES] the shifted word
	logic [STAGES:0][DW-1:0] stage;
	logic [STAGES-1:0] count;

	// one fixed-distance step: 00 sll, 01 sra, else ror
	function automatic logic [DW-1:0] shiftStep(
		input logic [DW-1:0] val,
		input logic [1:0] op,
		input int unsigned amt
	);
		logic [2*DW-1:0] doubled;
		doubled = {val, val} >> amt;
		case (op)
			2'b00: shiftStep = val << amt;
			2'b01: shiftStep = $signed(val) >>> amt;
			default: shiftStep = doubled[DW-1:0];
		endcase
	endfunction

	// count comes from the imm4 in B
	assign count = operands.aluB[STAGES-1:0];
	assign stage[0] = operands.aluA;

	// log shifter, steps of 1, 2, 4, 8
	for (genvar si = 0; si < STAGES; si++) begin : gStage
		assign stage[si+1] = count[si] ?
			shiftStep(stage[si], aluOp.shiftOp, 1 << si) : stage[si];
	end

	assign shiftResult = stage[STAGES];
	assign xorResult = operands.aluA ^ operands.aluB;

endmodule

/* hdl/resultSelect.sv */
`timescale 1ns/100ps
`include "exStage_settings.svh"

module resultSelect (
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input exPkg::opcodeT opcode,
	input exPkg::aluOpT aluOp,
	input logic [`DATA_WIDTH-1:0] claResult,
	input logic claOverflow,
	input logic [`DATA_WIDTH-1:0] shiftResult,
	input logic [`DATA_WIDTH-1:0] xorResult,
	output logic resultValid,
	output logic [`DATA_WIDTH-1:0] result,
	output exPkg::flagsT flags
);
	import exPkg::*;

	localparam int DW = `DATA_WIDTH;

	logic [DW-1:0] unitResult;
	flagsT nextFlags;

	always_comb begin
		case (aluOp.outSel)
			selXor: unitResult = xorResult;
			selShift: unitResult = shiftResult;
			default: unitResult = claResult;
		endcase
	end

	// flag rules per opcode, everything else holds
	always_comb begin
		nextFlags = flags;
		case (opcode)
			opAdd, opSub: begin
				nextFlags.z = (unitResult == '0);
				nextFlags.v = claOverflow;
				nextFlags.n = unitResult[DW-1];
			end
			// logic and shifts only touch z
			opXor, opSll, opSra, opRor: nextFlags.z = (unitResult == '0);
			default: ;
		endcase
	end

	// one result per strobe, valid the cycle after
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			result <= '0;
			flags <= '0;
		end else begin
			resultValid <= issueValid;
			if (issueValid) begin
				result <= unitResult;
				flags <= nextFlags;
			end
		end
	end

endmodule

/* hdl/exStage.sv */
`timescale 1ns/100ps
`include "exStage_settings.svh"

module exStage (
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input exPkg::instrT instr,
	input logic [`DATA_WIDTH-1:0] regData1,
	input logic [`DATA_WIDTH-1:0] regData2,
	input logic [`DATA_WIDTH-1:0] pcs,
	input logic [`DATA_WIDTH-1:0] aluOutMem,
	input logic [`DATA_WIDTH-1:0] writeData,
	input exPkg::fwdSelT forwardA,
	input exPkg::fwdSelT forwardB,
	output logic resultValid,
	output logic [`DATA_WIDTH-1:0] result,
	output exPkg::flagsT flags,
	output logic [`DATA_WIDTH-1:0] regDataB
);
	import exPkg::*;

	localparam int DW = `DATA_WIDTH;

	operandsT operands;
	aluOpT aluOp;
	logic [DW-1:0] claResult, shiftResult, xorResult;
	logic claOverflow;

	////////////////////////////////////////////////////////////////////////////
	// combinational operand path, then both units in parallel
	////////////////////////////////////////////////////////////////////////////

	aluOperandFormat uFormat (
		.instr(instr),
		.regData1(regData1),
		.regData2(regData2),
		.pcs(pcs),
		.aluOutMem(aluOutMem),
		.writeData(writeData),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.operands(operands),
		.aluOp(aluOp),
		.regDataB(regDataB)
	);

	claArith uCla (
		.operands(operands),
		.aluOp(aluOp),
		.claResult(claResult),
		.claOverflow(claOverflow)
	);

	shiftXor uShift (
		.operands(operands),
		.aluOp(aluOp),
		.shiftResult(shiftResult),
		.xorResult(xorResult)
	);

	// only registered stage of the block
	resultSelect uResult (
		.clk(clk),
		.rstN(rstN),
		.issueValid(issueValid),
		.opcode(instr.regFmt.opcode),
		.aluOp(aluOp),
		.claResult(claResult),
		.claOverflow(claOverflow),
		.shiftResult(shiftResult),
		.xorResult(xorResult),
		.resultValid(resultValid),
		.result(result),
		.flags(flags)
	);

endmodule

/* tests/exStageTb.sv */
`timescale 1ns/100ps
`include "exStage_settings.svh"

module exStageTb;
	import exPkg::*;

	localparam int DW = `DATA_WIDTH;

	// one issue and the response it should give
	typedef struct packed {
		logic [DW-1:0] instr;
		logic [DW-1:0] regData1;
		logic [DW-1:0] regData2;
		logic [DW-1:0] pcs;
		logic [DW-1:0] aluOutMem;
		logic [DW-1:0] writeData;
		fwdSelT forwardA;
		fwdSelT forwardB;
		logic [DW-1:0] expResult;
		flagsT expFlags;
		logic [DW-1:0] expRegDataB;
	} vectorT;

	logic clk, rstN, issueValid;
	instrT instr;
	logic [DW-1:0] regData1, regData2, pcs, aluOutMem, writeData;
	fwdSelT forwardA, forwardB;
	logic resultValid;
	logic [DW-1:0] result, regDataB;
	flagsT flags;

	vectorT vectors[$];
	int errors, checks, cycles, cycleLimit;

	exStage u_dut (
		.clk(clk),
		.rstN(rstN),
		.issueValid(issueValid),
		.instr(instr),
		.regData1(regData1),
		.regData2(regData2),
		.pcs(pcs),
		.aluOutMem(aluOutMem),
		.writeData(writeData),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.resultValid(resultValid),
		.result(result),
		.flags(flags),
		.regDataB(regDataB)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// abort if the table never drains
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycleLimit > 0 && cycles >= cycleLimit) begin
			$display("timeout: resultValid never finished the table");
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// instruction encoders and table building
	////////////////////////////////////////////////////////////////////////////

	// rd 1, rs 2, low nibble is rt or imm4
	function automatic logic [DW-1:0] regInstr(input opcodeT op, input logic [3:0] low);
		regInstr = {op, 4'h1, 4'h2, low};
	endfunction

	function automatic logic [DW-1:0] byteInstr(input opcodeT op, input logic [7:0] imm8);
		byteInstr = {op, 4'h1, imm8};
	endfunction

	// no forwarding, so the store data is plain regData2
	task automatic addVec(input logic [DW-1:0] ins, a, b, expR, input flagsT expF);
		vectorT v;
		v = '{instr: ins, regData1: a, regData2: b, pcs: '0, aluOutMem: 16'hDEAD,
			writeData: 16'hBEEF, forwardA: 2'd0, forwardB: 2'd0, expResult: expR,
			expFlags: expF, expRegDataB: b};
		vectors.push_back(v);
	endtask

	task automatic addFwdVec(input logic [DW-1:0] ins, a, b, pcsVal, memVal, wbVal,
		input fwdSelT fA, fB, input logic [DW-1:0] expR, input flagsT expF,
		input logic [DW-1:0] expB);
		vectorT v;
		v = '{instr: ins, regData1: a, regData2: b, pcs: pcsVal, aluOutMem: memVal,
			writeData: wbVal, forwardA: fA, forwardB: fB, expResult: expR,
			expFlags: expF, expRegDataB: expB};
		vectors.push_back(v);
	endtask

	// flags are {z, v, n} and carry over from row to row
	task automatic buildVectors();
		// add/sub with both saturation directions
		addVec(regInstr(opAdd, 4'h3), 16'h1234, 16'h0101, 16'h1335, 3'b000);
		addVec(regInstr(opAdd, 4'h3), 16'h7000, 16'h2000, 16'h7FFF, 3'b010);
		addVec(regInstr(opAdd, 4'h3), 16'h8000, 16'hFFFF, 16'h8000, 3'b011);
		addVec(regInstr(opSub, 4'h3), 16'h0005, 16'h0005, 16'h0000, 3'b100);
		addVec(regInstr(opSub, 4'h3), 16'h0003, 16'h0005, 16'hFFFE, 3'b001);
		addVec(regInstr(opSub, 4'h3), 16'h8000, 16'h0001, 16'h8000, 3'b011);
		// leaves v set and n clear for the rows that must hold them
		addVec(regInstr(opSub, 4'h3), 16'h7FFF, 16'hFFFF, 16'h7FFF, 3'b010);
		// lanes saturate apart, no carry from low lane into high
		addVec(regInstr(opPaddsb, 4'h3), 16'h7080, 16'h20FF, 16'h7F80, 3'b010);
		addVec(regInstr(opPaddsb, 4'h3), 16'h1003, 16'h02FE, 16'h1201, 3'b010);
		// 4 x 127 and 3 x -128 - 1
		addVec(regInstr(opRed, 4'h3), 16'h7F7F, 16'h7F7F, 16'h01FC, 3'b010);
		addVec(regInstr(opRed, 4'h3), 16'h8080, 16'h80FF, 16'hFE7F, 3'b010);
		// shifts touch z only, negative results leave n clear
		addVec(regInstr(opSll, 4'h0), 16'h1234, 16'hAAAA, 16'h1234, 3'b010);
		addVec(regInstr(opSll, 4'h1), 16'h8001, 16'hAAAA, 16'h0002, 3'b010);
		addVec(regInstr(opSll, 4'h7), 16'h1234, 16'hAAAA, 16'h1A00, 3'b010);
		addVec(regInstr(opSll, 4'hF), 16'h0002, 16'hAAAA, 16'h0000, 3'b110);
		addVec(regInstr(opSra, 4'h0), 16'h8421, 16'hAAAA, 16'h8421, 3'b010);
		addVec(regInstr(opSra, 4'h1), 16'h4000, 16'hAAAA, 16'h2000, 3'b010);
		addVec(regInstr(opSra, 4'h7), 16'h8000, 16'hAAAA, 16'hFF00, 3'b010);
		addVec(regInstr(opSra, 4'hF), 16'h8000, 16'hAAAA, 16'hFFFF, 3'b010);
		addVec(regInstr(opRor, 4'h0), 16'h00F0, 16'hAAAA, 16'h00F0, 3'b010);
		addVec(regInstr(opRor, 4'h1), 16'h0001, 16'hAAAA, 16'h8000, 3'b010);
		addVec(regInstr(opRor, 4'h7), 16'h1234, 16'hAAAA, 16'h6824, 3'b010);
		addVec(regInstr(opRor, 4'hF), 16'h8001, 16'hAAAA, 16'h0003, 3'b010);
		addVec(regInstr(opXor, 4'h3), 16'hFF00, 16'h0F0F, 16'hF00F, 3'b010);
		addVec(regInstr(opXor, 4'h3), 16'h5A5A, 16'h5A5A, 16'h0000, 3'b110);
		// address and byte forms, flags held at 110
		addVec(regInstr(opLw, 4'hF), 16'h1001, 16'h4444, 16'h0FFE, 3'b110);
		addVec(regInstr(opSw, 4'h7), 16'h2003, 16'h4444, 16'h2010, 3'b110);
		addVec(byteInstr(opLhb, 8'hCD), 16'h12AB, 16'h4444, 16'hCDAB, 3'b110);
		addVec(byteInstr(opLlb, 8'hCD), 16'h12AB, 16'h4444, 16'h12CD, 3'b110);
		addFwdVec(regInstr(opPcs, 4'h0), 16'h1111, 16'h4444, 16'h0246, 16'hDEAD,
			16'hBEEF, 2'd0, 2'd0, 16'h0246, 3'b110, 16'h4444);
		// forwarding codes, mem stage wins when both bits are set
		addFwdVec(regInstr(opAdd, 4'h3), 16'h9999, 16'h0001, 16'h0000, 16'h0100,
			16'hBEEF, 2'd2, 2'd0, 16'h0101, 3'b000, 16'h0001);
		addFwdVec(regInstr(opAdd, 4'h3), 16'h9999, 16'h8888, 16'h0000, 16'h0030,
			16'h0200, 2'd1, 2'd2, 16'h0230, 3'b000, 16'h0030);
		addFwdVec(regInstr(opAdd, 4'h3), 16'h0004, 16'h8888, 16'h0000, 16'hDEAD,
			16'h0500, 2'd0, 2'd1, 16'h0504, 3'b000, 16'h0500);
		addFwdVec(regInstr(opAdd, 4'h3), 16'h9999, 16'h8888, 16'h0000, 16'h0010,
			16'h0F00, 2'd3, 2'd3, 16'h0020, 3'b000, 16'h0010);
		// store data forwarded while B carries the offset
		addFwdVec(regInstr(opSw, 4'h1), 16'h0100, 16'h8888, 16'h0000, 16'hDEAD,
			16'h7777, 2'd0, 2'd1, 16'h0102, 3'b000, 16'h7777);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// drive and check
	////////////////////////////////////////////////////////////////////////////

	task automatic applyVec(input int idx);
		instr = vectors[idx].instr;
		regData1 = vectors[idx].regData1;
		regData2 = vectors[idx].regData2;
		pcs = vectors[idx].pcs;
		aluOutMem = vectors[idx].aluOutMem;
		writeData = vectors[idx].writeData;
		forwardA = vectors[idx].forwardA;
		forwardB = vectors[idx].forwardB;
		issueValid = 1'b1;
	endtask

	// registered outputs, one cycle after the issue
	task automatic checkResult(input int idx);
		checks++;
		if (resultValid !== 1'b1) begin
			errors++;
			$display("CHECK FAILED at %0t: vector %0d resultValid is %b", $time, idx,
				resultValid);
		end
		if (result !== vectors[idx].expResult) begin
			errors++;
			$display("CHECK FAILED at %0t: vector %0d result %h, expected %h", $time, idx,
				result, vectors[idx].expResult);
		end
		if (flags !== vectors[idx].expFlags) begin
			errors++;
			$display("CHECK FAILED at %0t: vector %0d flags %b, expected %b", $time, idx,
				flags, vectors[idx].expFlags);
		end
	endtask

	// combinational store data, same cycle as the issue
	task automatic checkStoreData(input int idx);
		checks++;
		if (regDataB !== vectors[idx].expRegDataB) begin
			errors++;
			$display("CHECK FAILED at %0t: vector %0d regDataB %h, expected %h", $time, idx,
				regDataB, vectors[idx].expRegDataB);
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		cycles = 0;
		cycleLimit = 0;
		rstN = 1'b0;
		issueValid = 1'b0;
		instr = '0;
		regData1 = '0;
		regData2 = '0;
		pcs = '0;
		aluOutMem = '0;
		writeData = '0;
		forwardA = '0;
		forwardB = '0;
		buildVectors();
		cycleLimit = 20 + 3 * vectors.size();

		repeat (10) @(negedge clk);
		rstN = 1'b1;

		// idle after reset
		@(negedge clk);
		checks++;
		if (resultValid !== 1'b0 || result !== '0 || flags !== '0) begin
			errors++;
			$display("CHECK FAILED at %0t: after reset valid %b result %h flags %b", $time,
				resultValid, result, flags);
		end

		// back to back issue, every cycle
		for (int i = 0; i < vectors.size(); i++) begin
			@(negedge clk);
			if (i > 0)
				checkResult(i - 1);
			applyVec(i);
			#10;
			checkStoreData(i);
		end
		@(negedge clk);
		checkResult(vectors.size() - 1);
		issueValid = 1'b0;

		// valid drops once the strobes stop
		@(negedge clk);
		checks++;
		if (resultValid !== 1'b0) begin
			errors++;
			$display("CHECK FAILED at %0t: resultValid still high without a strobe", $time);
		end

		$display("checks: %0d, errors: %0d, vectors: %0d", checks, errors, vectors.size());
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* exStage.f */
+incdir+hdl
hdl/exPkg.sv
hdl/aluOperandFormat.sv
hdl/claArith.sv
hdl/shiftXor.sv
hdl/resultSelect.sv
hdl/exStage.sv
tests/exStageTb.sv
